//--- downsize_params.svh
// Widths assume a 64-bit subordinate and a 32-bit manager W path with one strobe bit per byte
`ifndef DOWNSIZE_PARAMS_SVH
`define DOWNSIZE_PARAMS_SVH

// ------------------------------
// Address and data widths
// ------------------------------
`define DS_ADDR_W     32
`define DS_SI_DATA_W  64
`define DS_MI_DATA_W  32
`define DS_ID_W       4

// ------------------------------
// Burst limits and AxCACHE bits
// ------------------------------

// Largest len a single manager burst can carry
`define DS_MAX_BURST_LEN    255

// Position of the modifiable bit inside AxCACHE
`define DS_CACHE_MODIFIABLE 1

`endif

//--- downsize_pkg.sv
// Type widths follow downsize_params.svh; only the 64-to-32 write downsizer uses them
`default_nettype none

`include "downsize_params.svh"

package downsize_pkg;

  // AXI burst encodings, reserved value 2'b11 unused
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Write path mode of the current burst
  typedef enum logic [1:0] {
    WR_IDLE        = 2'b00,
    WR_PASSTHROUGH = 2'b01,
    WR_DOWNSIZE    = 2'b10
  } wr_mode_e;

  typedef logic [`DS_ADDR_W-1:0]      addr_t;
  typedef logic [7:0]                 len_t;
  typedef logic [2:0]                 size_t;
  typedef logic [8:0]                 full_len_t;
  typedef logic [`DS_SI_DATA_W-1:0]   si_data_t;
  typedef logic [`DS_SI_DATA_W/8-1:0] si_strb_t;
  typedef logic [`DS_MI_DATA_W-1:0]   mi_data_t;
  typedef logic [`DS_MI_DATA_W/8-1:0] mi_strb_t;
  typedef logic [`DS_ID_W-1:0]        id_t;

endpackage

`default_nettype wire

//--- write_cmd_planner.sv
// One burst at a time; downsized bursts longer than 256 manager beats are clamped, not split
`default_nettype none

`include "downsize_params.svh"

module write_cmd_planner import downsize_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Subordinate AW
  input  wire id_t        slv_aw_id_i,
  input  wire addr_t      slv_aw_addr_i,
  input  wire len_t       slv_aw_len_i,
  input  wire size_t      slv_aw_size_i,
  input  wire burst_e     slv_aw_burst_i,
  input  wire logic [3:0] slv_aw_cache_i,
  input  wire logic       slv_aw_valid_i,
  output logic            slv_aw_ready_o,
  // Manager AW
  output id_t             mst_aw_id_o,
  output addr_t           mst_aw_addr_o,
  output len_t            mst_aw_len_o,
  output size_t           mst_aw_size_o,
  output burst_e          mst_aw_burst_o,
  output logic [3:0]      mst_aw_cache_o,
  output logic            mst_aw_valid_o,
  input  wire logic       mst_aw_ready_i,
  // Plan towards the serializer
  output wr_mode_e        plan_mode_o,
  output addr_t           plan_addr_o,
  output size_t           plan_size_o,
  output logic            aw_done_o,
  input  wire logic       burst_done_i
);

  localparam int unsigned MiBytes = `DS_MI_DATA_W / 8;
  localparam int unsigned MiShift = $clog2(MiBytes);

  wr_mode_e  mode_q;
  logic      aw_valid_q;
  logic      aw_done_q;
  logic      aw_hs;
  logic      do_downsize;
  addr_t     size_mask;
  addr_t     align_adj;
  size_t     ratio_shift;
  full_len_t full_len;
  len_t      down_len;

  // ------------------------------
  // Burst plan from subordinate AW
  // ------------------------------
  assign slv_aw_ready_o = (mode_q == WR_IDLE);
  assign aw_hs          = slv_aw_valid_i && slv_aw_ready_o;

  assign do_downsize = slv_aw_cache_i[`DS_CACHE_MODIFIABLE] &&
                       (slv_aw_burst_i == BURST_INCR) &&
                       (slv_aw_size_i > size_t'(MiShift));

  always_comb begin
    size_mask   = (addr_t'(1) << slv_aw_size_i) - addr_t'(1);
    // Manager words skipped inside the first wide beat
    align_adj   = (slv_aw_addr_i & size_mask & ~addr_t'(MiBytes - 1)) >> MiShift;
    // Ratio is a power of two, so the multiply is a shift
    ratio_shift = slv_aw_size_i - size_t'(MiShift);
    full_len    = ((full_len_t'(slv_aw_len_i) + full_len_t'(1)) << ratio_shift) -
                  full_len_t'(align_adj) - full_len_t'(1);
    if (full_len > full_len_t'(`DS_MAX_BURST_LEN)) begin
      down_len = len_t'(`DS_MAX_BURST_LEN);
    end else begin
      down_len = full_len[7:0];
    end
  end

  // ------------------------------
  // Mode FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= WR_IDLE;
      aw_valid_q <= 1'b0;
      aw_done_q  <= 1'b0;
    end else begin
      case (mode_q)
        WR_IDLE: begin
          if (aw_hs) begin
            mode_q     <= do_downsize ? WR_DOWNSIZE : WR_PASSTHROUGH;
            aw_valid_q <= 1'b1;
          end
        end
        default: begin
          if (aw_valid_q && mst_aw_ready_i) begin
            aw_valid_q <= 1'b0;
            aw_done_q  <= 1'b1;
          end
          // Final manager W beat closes the burst
          if (burst_done_i) begin
            mode_q    <= WR_IDLE;
            aw_done_q <= 1'b0;
          end
        end
      endcase
    end
  end

  // Captured command fields
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      mst_aw_id_o    <= slv_aw_id_i;
      mst_aw_addr_o  <= slv_aw_addr_i;
      mst_aw_burst_o <= slv_aw_burst_i;
      mst_aw_cache_o <= slv_aw_cache_i;
      mst_aw_len_o   <= do_downsize ? down_len : slv_aw_len_i;
      mst_aw_size_o  <= do_downsize ? size_t'(MiShift) : slv_aw_size_i;
      plan_size_o    <= slv_aw_size_i;
    end
  end

  assign mst_aw_valid_o = aw_valid_q;
  assign plan_mode_o    = mode_q;
  assign plan_addr_o    = mst_aw_addr_o;
  assign aw_done_o      = aw_done_q;

endmodule

`default_nettype wire

//--- wide_word_buffer.sv
// Holds a single wide W beat; ready depends combinationally on word_pop_i
`default_nettype none

module wide_word_buffer import downsize_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Subordinate W
  input  wire si_data_t slv_w_data_i,
  input  wire si_strb_t slv_w_strb_i,
  input  wire logic     slv_w_last_i,
  input  wire logic     slv_w_valid_i,
  output logic          slv_w_ready_o,
  // Stored word towards the serializer
  output logic          word_valid_o,
  output si_data_t      word_data_o,
  output si_strb_t      word_strb_o,
  output logic          word_last_o,
  input  wire logic     word_pop_i
);

  logic     full_q;
  logic     load;
  si_data_t data_q;
  si_strb_t strb_q;
  logic     last_q;

  // Free slot, or the held word leaves this cycle
  assign slv_w_ready_o = !full_q || word_pop_i;
  assign load          = slv_w_valid_i && slv_w_ready_o;

  // ------------------------------
  // Occupancy
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (word_pop_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= slv_w_data_i;
      strb_q <= slv_w_strb_i;
      last_q <= slv_w_last_i;
    end
  end

  assign word_valid_o = full_q;
  assign word_data_o  = data_q;
  assign word_strb_o  = strb_q;
  assign word_last_o  = last_q;

endmodule

`default_nettype wire

//--- lane_serializer.sv
// Beat address steps as for INCR in both modes; FIXED passthrough bursts advance it as well
`default_nettype none

`include "downsize_params.svh"

module lane_serializer import downsize_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Plan from the planner
  input  wire wr_mode_e plan_mode_i,
  input  wire addr_t    plan_addr_i,
  input  wire size_t    plan_size_i,
  input  wire len_t     mst_aw_len_i,
  input  wire logic     aw_done_i,
  // Wide word from the buffer
  input  wire logic     word_valid_i,
  input  wire si_data_t word_data_i,
  input  wire si_strb_t word_strb_i,
  input  wire logic     word_last_i,
  output logic          word_pop_o,
  // Manager W
  output mi_data_t      mst_w_data_o,
  output mi_strb_t      mst_w_strb_o,
  output logic          mst_w_last_o,
  output logic          mst_w_valid_o,
  input  wire logic     mst_w_ready_i,
  output logic          burst_done_o
);

  localparam int unsigned SiBytes = `DS_SI_DATA_W / 8;
  localparam int unsigned MiBytes = `DS_MI_DATA_W / 8;
  localparam int unsigned SiShift = $clog2(SiBytes);
  localparam int unsigned MiShift = $clog2(MiBytes);

  logic  active_q;
  addr_t addr_q;
  len_t  rem_q;
  addr_t cur_addr;
  len_t  cur_rem;
  size_t beat_size;
  addr_t beat_mask;
  addr_t orig_mask;
  addr_t next_addr;
  logic  last_beat;
  logic  w_hs;
  logic  crossed;

  // First beat may go out in the cycle aw_done rises
  assign cur_addr  = active_q ? addr_q : plan_addr_i;
  assign cur_rem   = active_q ? rem_q : mst_aw_len_i;
  assign beat_size = (plan_mode_i == WR_DOWNSIZE) ? size_t'(MiShift) : plan_size_i;

  // ------------------------------
  // Byte-lane steering
  // ------------------------------
  always_comb begin
    int si_off;
    int mi_off;
    int span;
    int lane;
    si_off       = int'(cur_addr[SiShift-1:0]);
    mi_off       = int'(cur_addr[MiShift-1:0]);
    span         = 1 << beat_size;
    mst_w_data_o = '0;
    mst_w_strb_o = '0;
    for (int b = 0; b < SiBytes; b++) begin
      lane = b + mi_off - si_off;
      if ((b >= si_off) && (b - si_off < span) && (lane < MiBytes)) begin
        mst_w_data_o[8*lane +: 8] = word_data_i[8*b +: 8];
        mst_w_strb_o[lane]        = word_strb_i[b];
      end
    end
  end

  assign mst_w_valid_o = word_valid_i && aw_done_i;
  assign last_beat     = (cur_rem == len_t'(0));
  assign mst_w_last_o  = last_beat && word_last_i;
  assign w_hs          = mst_w_valid_o && mst_w_ready_i;
  assign burst_done_o  = w_hs && last_beat;

  // Next aligned beat address
  assign beat_mask = (addr_t'(1) << beat_size) - addr_t'(1);
  assign next_addr = (cur_addr & ~beat_mask) + (addr_t'(1) << beat_size);

  // Did we step into the next wide word
  assign orig_mask = (addr_t'(1) << plan_size_i) - addr_t'(1);
  assign crossed   = (next_addr & ~orig_mask) != (cur_addr & ~orig_mask);

  always_comb begin
    word_pop_o = 1'b0;
    if (w_hs) begin
      if ((plan_mode_i == WR_PASSTHROUGH) || last_beat || crossed) begin
        word_pop_o = 1'b1;
      end
    end
  end

  // ------------------------------
  // Beat tracking
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else if (burst_done_o) begin
      active_q <= 1'b0;
    end else if (aw_done_i) begin
      active_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      addr_q <= next_addr;
      rem_q  <= cur_rem - len_t'(1);
    end else if (!active_q) begin
      addr_q <= plan_addr_i;
      rem_q  <= mst_aw_len_i;
    end
  end

endmodule

`default_nettype wire

//--- axi_write_downsizer.sv
// Write half only, 64-bit subordinate to 32-bit manager, one burst in flight; B passes straight through
`default_nettype none

module axi_write_downsizer import downsize_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Subordinate AW
  input  wire id_t        slv_aw_id_i,
  input  wire addr_t      slv_aw_addr_i,
  input  wire len_t       slv_aw_len_i,
  input  wire size_t      slv_aw_size_i,
  input  wire burst_e     slv_aw_burst_i,
  input  wire logic [3:0] slv_aw_cache_i,
  input  wire logic       slv_aw_valid_i,
  output logic            slv_aw_ready_o,
  // Subordinate W
  input  wire si_data_t   slv_w_data_i,
  input  wire si_strb_t   slv_w_strb_i,
  input  wire logic       slv_w_last_i,
  input  wire logic       slv_w_valid_i,
  output logic            slv_w_ready_o,
  // Subordinate B
  output id_t             slv_b_id_o,
  output logic [1:0]      slv_b_resp_o,
  output logic            slv_b_valid_o,
  input  wire logic       slv_b_ready_i,
  // Manager AW
  output id_t             mst_aw_id_o,
  output addr_t           mst_aw_addr_o,
  output len_t            mst_aw_len_o,
  output size_t           mst_aw_size_o,
  output burst_e          mst_aw_burst_o,
  output logic [3:0]      mst_aw_cache_o,
  output logic            mst_aw_valid_o,
  input  wire logic       mst_aw_ready_i,
  // Manager W
  output mi_data_t        mst_w_data_o,
  output mi_strb_t        mst_w_strb_o,
  output logic            mst_w_last_o,
  output logic            mst_w_valid_o,
  input  wire logic       mst_w_ready_i,
  // Manager B
  input  wire id_t        mst_b_id_i,
  input  wire logic [1:0] mst_b_resp_i,
  input  wire logic       mst_b_valid_i,
  output logic            mst_b_ready_o
);

  wr_mode_e plan_mode;
  addr_t    plan_addr;
  size_t    plan_size;
  logic     aw_done;
  logic     burst_done;
  logic     word_valid;
  si_data_t word_data;
  si_strb_t word_strb;
  logic     word_last;
  logic     word_pop;

  // ------------------------------
  // AW planning
  // ------------------------------
  write_cmd_planner u_planner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_size_i  (slv_aw_size_i),
    .slv_aw_burst_i (slv_aw_burst_i),
    .slv_aw_cache_i (slv_aw_cache_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_burst_o (mst_aw_burst_o),
    .mst_aw_cache_o (mst_aw_cache_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .plan_mode_o    (plan_mode),
    .plan_addr_o    (plan_addr),
    .plan_size_o    (plan_size),
    .aw_done_o      (aw_done),
    .burst_done_i   (burst_done)
  );

  // ------------------------------
  // W path
  // ------------------------------
  wide_word_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_w_data_i  (slv_w_data_i),
    .slv_w_strb_i  (slv_w_strb_i),
    .slv_w_last_i  (slv_w_last_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .word_valid_o  (word_valid),
    .word_data_o   (word_data),
    .word_strb_o   (word_strb),
    .word_last_o   (word_last),
    .word_pop_i    (word_pop)
  );

  lane_serializer u_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .plan_mode_i   (plan_mode),
    .plan_addr_i   (plan_addr),
    .plan_size_i   (plan_size),
    .mst_aw_len_i  (mst_aw_len_o),
    .aw_done_i     (aw_done),
    .word_valid_i  (word_valid),
    .word_data_i   (word_data),
    .word_strb_i   (word_strb),
    .word_last_i   (word_last),
    .word_pop_o    (word_pop),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i),
    .burst_done_o  (burst_done)
  );

  // B response, no latency
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Free-running 10 ns clock; reset is held low for the first two rising edges
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release lines up with the stimulus offset
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- downsizer_assert.sv
// Protocol checks bound into axi_write_downsizer; idle while rst_ni is low
`default_nettype none

`include "downsize_params.svh"

module downsizer_assert import downsize_pkg::*; (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic       slv_aw_valid_i,
  input wire logic       slv_aw_ready_o,
  input wire addr_t      slv_aw_addr_i,
  input wire len_t       slv_aw_len_i,
  input wire size_t      slv_aw_size_i,
  input wire burst_e     slv_aw_burst_i,
  input wire logic [3:0] slv_aw_cache_i,
  input wire logic       mst_aw_valid_o,
  input wire logic       mst_aw_ready_i,
  input wire addr_t      mst_aw_addr_o,
  input wire len_t       mst_aw_len_o,
  input wire logic       mst_w_valid_o,
  input wire logic       mst_w_ready_i,
  input wire mi_data_t   mst_w_data_o,
  input wire mi_strb_t   mst_w_strb_o,
  input wire logic       mst_w_last_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MiShift = $clog2(`DS_MI_DATA_W / 8);

  logic slv_aw_hs;
  logic slv_down;
  int   mst_beats;
  logic busy_q;

  assign slv_aw_hs = slv_aw_valid_i && slv_aw_ready_o;
  assign slv_down  = slv_aw_cache_i[`DS_CACHE_MODIFIABLE] &&
                     (slv_aw_burst_i == BURST_INCR) &&
                     (slv_aw_size_i > size_t'(MiShift));

  // Manager beats the command needs, before any clamp
  always_comb begin
    mst_beats = int'(slv_aw_len_i) + 1;
    if (slv_down) begin
      mst_beats = mst_beats << (slv_aw_size_i - size_t'(MiShift));
    end
  end

  // Burst open from subordinate AW until the last manager W beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (slv_aw_hs) begin
      busy_q <= 1'b1;
    end else if (mst_w_valid_o && mst_w_ready_i && mst_w_last_o) begin
      busy_q <= 1'b0;
    end
  end

  // ------------------------------
  // Valid held until ready
  // ------------------------------
  slv_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i && !slv_aw_ready_o |=> slv_aw_valid_i && $stable(slv_aw_addr_i))
    else $error("subordinate AW valid or address changed before ready");

  mst_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=>
      mst_aw_valid_o && $stable(mst_aw_addr_o) && $stable(mst_aw_len_o))
    else $error("manager AW valid or payload changed before ready");

  mst_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_data_o) &&
      $stable(mst_w_strb_o) && $stable(mst_w_last_o))
    else $error("manager W valid or payload changed before ready");

  // ------------------------------
  // Burst limits and sequencing
  // ------------------------------
  mst_len_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_hs |-> (mst_beats <= `DS_MAX_BURST_LEN + 1))
    else $error("downsized burst longer than one manager burst");

  // No new command while the current burst is still open
  aw_blocked_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> !slv_aw_ready_o)
    else $error("subordinate AW ready while a burst is still open");

endmodule

bind axi_write_downsizer downsizer_assert u_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .slv_aw_valid_i (slv_aw_valid_i),
  .slv_aw_ready_o (slv_aw_ready_o),
  .slv_aw_addr_i  (slv_aw_addr_i),
  .slv_aw_len_i   (slv_aw_len_i),
  .slv_aw_size_i  (slv_aw_size_i),
  .slv_aw_burst_i (slv_aw_burst_i),
  .slv_aw_cache_i (slv_aw_cache_i),
  .mst_aw_valid_o (mst_aw_valid_o),
  .mst_aw_ready_i (mst_aw_ready_i),
  .mst_aw_addr_o  (mst_aw_addr_o),
  .mst_aw_len_o   (mst_aw_len_o),
  .mst_w_valid_o  (mst_w_valid_o),
  .mst_w_ready_i  (mst_w_ready_i),
  .mst_w_data_o   (mst_w_data_o),
  .mst_w_strb_o   (mst_w_strb_o),
  .mst_w_last_o   (mst_w_last_o)
);

`default_nettype wire

//--- tb_axi_write_downsizer.sv
// Random INCR and FIXED bursts, no WRAP; narrow beats of size 1 start halfword aligned
`default_nettype none

`include "downsize_params.svh"

module tb_axi_write_downsizer import downsize_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumBursts      = 200;
  localparam int CyclesPerBurst = 300;
  localparam int TimeoutCycles  = NumBursts * CyclesPerBurst;
  localparam int MiBytes        = `DS_MI_DATA_W / 8;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    size_t      size;
    burst_e     burst;
    logic [3:0] cache;
  } aw_cmd_t;

  typedef struct packed {
    si_data_t data;
    si_strb_t strb;
    logic     last;
  } si_beat_t;

  typedef struct packed {
    mi_data_t data;
    mi_strb_t strb;
    mi_strb_t sel;
    logic     last;
  } mi_beat_t;

  logic clk;
  logic rst_n;

  id_t        slv_aw_id;
  addr_t      slv_aw_addr;
  len_t       slv_aw_len;
  size_t      slv_aw_size;
  burst_e     slv_aw_burst;
  logic [3:0] slv_aw_cache;
  logic       slv_aw_valid;
  logic       slv_aw_ready;
  si_data_t   slv_w_data;
  si_strb_t   slv_w_strb;
  logic       slv_w_last;
  logic       slv_w_valid;
  logic       slv_w_ready;
  id_t        slv_b_id;
  logic [1:0] slv_b_resp;
  logic       slv_b_valid;
  logic       slv_b_ready;
  id_t        mst_aw_id;
  addr_t      mst_aw_addr;
  len_t       mst_aw_len;
  size_t      mst_aw_size;
  burst_e     mst_aw_burst;
  logic [3:0] mst_aw_cache;
  logic       mst_aw_valid;
  logic       mst_aw_ready;
  mi_data_t   mst_w_data;
  mi_strb_t   mst_w_strb;
  logic       mst_w_last;
  logic       mst_w_valid;
  logic       mst_w_ready;
  id_t        mst_b_id;
  logic [1:0] mst_b_resp;
  logic       mst_b_valid;
  logic       mst_b_ready;

  // Model state
  aw_cmd_t    exp_aw_q[$];
  mi_beat_t   exp_w_q[$];
  si_beat_t   si_q[$];
  id_t        open_ids[$];
  id_t        b_id_q[$];
  logic [1:0] b_resp_q[$];
  logic [31:0] lfsr_state;
  logic       slv_aw_taken;
  logic       slv_w_taken;
  logic       mst_b_taken;
  int         bursts_sent;
  int         bursts_done;
  int         cycle_count;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  axi_write_downsizer u_axi_write_downsizer (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .slv_aw_id_i    (slv_aw_id),
    .slv_aw_addr_i  (slv_aw_addr),
    .slv_aw_len_i   (slv_aw_len),
    .slv_aw_size_i  (slv_aw_size),
    .slv_aw_burst_i (slv_aw_burst),
    .slv_aw_cache_i (slv_aw_cache),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_data_i   (slv_w_data),
    .slv_w_strb_i   (slv_w_strb),
    .slv_w_last_i   (slv_w_last),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_id_o     (slv_b_id),
    .slv_b_resp_o   (slv_b_resp),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_id_o    (mst_aw_id),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_aw_len_o   (mst_aw_len),
    .mst_aw_size_o  (mst_aw_size),
    .mst_aw_burst_o (mst_aw_burst),
    .mst_aw_cache_o (mst_aw_cache),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_data_o   (mst_w_data),
    .mst_w_strb_o   (mst_w_strb),
    .mst_w_last_o   (mst_w_last),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_id_i     (mst_b_id),
    .mst_b_resp_i   (mst_b_resp),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // ------------------------------
  // Burst generator and model
  // ------------------------------
  task automatic plan_burst();
    int       kind;
    logic     down;
    int       ratio;
    int       adj;
    int       n_beats;
    int       beat_bytes;
    int       word;
    addr_t    a;
    addr_t    x;
    addr_t    hi;
    aw_cmd_t  exp;
    si_beat_t si;
    mi_beat_t mi;
    si_beat_t words[$];
    kind         = int'(rand_bits(2));
    slv_aw_id    = id_t'(rand_bits(4));
    slv_aw_addr  = addr_t'(rand_bits(20));
    slv_aw_cache = 4'(rand_bits(4));
    if (kind < 2) begin
      slv_aw_cache[`DS_CACHE_MODIFIABLE] = 1'b1;
      slv_aw_burst = BURST_INCR;
      slv_aw_size  = size_t'(3);
      if (rand_bits(1) == 1) begin
        slv_aw_len = len_t'(rand_bits(7));
      end else begin
        slv_aw_len = len_t'(rand_bits(4));
      end
    end else begin
      slv_aw_size = size_t'(rand_bits(2));
      if (slv_aw_size == size_t'(3)) begin
        slv_aw_size = size_t'(2);
      end
      slv_aw_burst = (kind == 2) ? BURST_INCR : BURST_FIXED;
      slv_aw_len   = (kind == 2) ? len_t'(rand_bits(6)) : len_t'(rand_bits(4));
    end
    if (slv_aw_size == size_t'(1)) begin
      slv_aw_addr[0] = 1'b0;
    end

    // Downsize only modifiable INCR bursts wider than a manager word
    down = slv_aw_cache[`DS_CACHE_MODIFIABLE] && (slv_aw_burst == BURST_INCR) &&
           ((1 << slv_aw_size) > MiBytes);
    exp.id    = slv_aw_id;
    exp.addr  = slv_aw_addr;
    exp.burst = slv_aw_burst;
    exp.cache = slv_aw_cache;
    if (down) begin
      ratio      = (1 << slv_aw_size) / MiBytes;
      adj        = int'(slv_aw_addr & addr_t'((1 << slv_aw_size) - 1)) / MiBytes;
      n_beats    = (int'(slv_aw_len) + 1) * ratio - adj;
      beat_bytes = MiBytes;
      exp.size   = size_t'($clog2(MiBytes));
    end else begin
      n_beats    = int'(slv_aw_len) + 1;
      beat_bytes = 1 << slv_aw_size;
      exp.size   = slv_aw_size;
    end
    exp.len = len_t'(n_beats - 1);
    exp_aw_q.push_back(exp);

    for (int w = 0; w <= int'(slv_aw_len); w++) begin
      si.data = {rand_bits(32), rand_bits(32)};
      si.strb = si_strb_t'(rand_bits(8));
      si.last = (w == int'(slv_aw_len));
      words.push_back(si);
      si_q.push_back(si);
    end

    // Beat address advances as INCR in every mode
    a = slv_aw_addr;
    for (int j = 0; j < n_beats; j++) begin
      if (down) begin
        word = int'((a >> 3) - (slv_aw_addr >> 3));
      end else begin
        word = j;
      end
      hi = (a & ~addr_t'(beat_bytes - 1)) + addr_t'(beat_bytes);
      mi = '0;
      x  = a;
      while (x < hi) begin
        // Byte x sits in wide lane x[2:0] and manager lane x[1:0]
        mi.sel[x[1:0]]          = 1'b1;
        mi.strb[x[1:0]]         = words[word].strb[x[2:0]];
        mi.data[8*x[1:0] +: 8]  = words[word].data[8*x[2:0] +: 8];
        x = x + addr_t'(1);
      end
      mi.last = (j == n_beats - 1);
      exp_w_q.push_back(mi);
      a = hi;
    end
  endtask

  // ------------------------------
  // Edge sampling and checks
  // ------------------------------
  task automatic sample_channels();
    aw_cmd_t  exp_aw;
    mi_beat_t exp_w;
    mi_data_t mask;
    slv_aw_taken = slv_aw_valid && slv_aw_ready;
    slv_w_taken  = slv_w_valid && slv_w_ready;
    mst_b_taken  = mst_b_valid && mst_b_ready;
    if (mst_aw_valid && mst_aw_ready) begin
      check_true("manager AW seen with no burst pending", exp_aw_q.size() > 0);
      exp_aw = exp_aw_q.pop_front();
      check_value("AW id", 64'(mst_aw_id), 64'(exp_aw.id));
      check_value("AW addr", 64'(mst_aw_addr), 64'(exp_aw.addr));
      check_value("AW len", 64'(mst_aw_len), 64'(exp_aw.len));
      check_value("AW size", 64'(mst_aw_size), 64'(exp_aw.size));
      check_value("AW burst", 64'(mst_aw_burst), 64'(exp_aw.burst));
      check_value("AW cache", 64'(mst_aw_cache), 64'(exp_aw.cache));
      open_ids.push_back(exp_aw.id);
    end
    if (mst_w_valid && mst_w_ready) begin
      check_true("manager W beat seen with none expected", exp_w_q.size() > 0);
      exp_w = exp_w_q.pop_front();
      mask  = '0;
      for (int i = 0; i < MiBytes; i++) begin
        if (exp_w.sel[i]) begin
          mask[8*i +: 8] = 8'hff;
        end
      end
      check_value("W data", 64'(mst_w_data & mask), 64'(exp_w.data));
      check_value("W strb", 64'(mst_w_strb), 64'(exp_w.strb));
      check_value("W last", 64'(mst_w_last), 64'(exp_w.last));
      if (exp_w.last) begin
        b_id_q.push_back(open_ids.pop_front());
        b_resp_q.push_back(2'(rand_bits(2)));
      end
    end
    if (slv_b_valid && slv_b_ready) begin
      check_true("subordinate B seen with no response driven", b_id_q.size() > 0);
      check_value("B id", 64'(slv_b_id), 64'(b_id_q[0]));
      check_value("B resp", 64'(slv_b_resp), 64'(b_resp_q[0]));
      bursts_done++;
    end
  endtask

  // Inputs change 1 ns after the edge
  task automatic drive_channels();
    if (slv_aw_taken) begin
      slv_aw_valid = 1'b0;
    end
    if (!slv_aw_valid && bursts_sent < NumBursts && rand_bits(2) != 0) begin
      plan_burst();
      slv_aw_valid = 1'b1;
      bursts_sent++;
    end
    if (slv_w_taken) begin
      si_q.delete(0);
      slv_w_valid = 1'b0;
    end
    if (!slv_w_valid && si_q.size() > 0 && rand_bits(2) != 0) begin
      slv_w_data  = si_q[0].data;
      slv_w_strb  = si_q[0].strb;
      slv_w_last  = si_q[0].last;
      slv_w_valid = 1'b1;
    end
    if (mst_b_taken) begin
      b_id_q.delete(0);
      b_resp_q.delete(0);
      mst_b_valid = 1'b0;
    end
    if (!mst_b_valid && b_id_q.size() > 0 && rand_bits(1) == 1) begin
      mst_b_id    = b_id_q[0];
      mst_b_resp  = b_resp_q[0];
      mst_b_valid = 1'b1;
    end
    mst_aw_ready = (rand_bits(2) != 0);
    mst_w_ready  = (rand_bits(2) != 0);
    slv_b_ready  = (rand_bits(1) == 1);
  endtask

  initial begin : main_flow
    lfsr_state   = 32'hb12b;
    bursts_sent  = 0;
    bursts_done  = 0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_aw_len   = '0;
    slv_aw_size  = '0;
    slv_aw_burst = BURST_FIXED;
    slv_aw_cache = '0;
    slv_aw_valid = 1'b0;
    slv_w_data   = '0;
    slv_w_strb   = '0;
    slv_w_last   = 1'b0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b_id     = '0;
    mst_b_resp   = '0;
    mst_b_valid  = 1'b0;
    @(posedge rst_n);
    while (bursts_done < NumBursts) begin
      @(posedge clk);
      sample_channels();
      #1;
      drive_channels();
    end
    check_true("manager AW commands never issued", exp_aw_q.size() == 0);
    check_true("manager W beats missing at end of run", exp_w_q.size() == 0);
    check_true("subordinate W beats never accepted", si_q.size() == 0);
    $display("Simulation PASSED");
    $finish;
  end

  // Run limit
  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TimeoutCycles) begin
        $display("Timeout after %0d cycles, %0d of %0d bursts answered",
                 cycle_count, bursts_done, NumBursts);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
downsize_pkg.sv
write_cmd_planner.sv
wide_word_buffer.sv
lane_serializer.sv
axi_write_downsizer.sv
tb_clock_gen.sv
downsizer_assert.sv
tb_axi_write_downsizer.sv

//--- run.sh
#!/bin/sh
# Build and run the downsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_write_downsizer -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
